//--- design/hex_oled_pkg.sv
package hex_oled_pkg;

    localparam int X_SIZE        = 96;
    localparam int Y_SIZE        = 64;
    localparam int COLOR_BITS    = 16;
    localparam int CELL_W        = 6;
    localparam int CELL_H        = 8;
    localparam int CHARS_PER_ROW = 16;
    localparam int TEXT_ROWS     = 2;
    localparam int RESET_CYCLES  = 64;
    localparam int INIT_LEN      = 44;

    // SSD1331 bring-up for 65k colour with x mirrored over the full 96x64 window
    localparam logic [0:INIT_LEN-1][7:0] INIT_SEQ = {
        8'h2E, 8'hAE, 8'hA0, 8'h72, 8'hA1, 8'h00, 8'hA2, 8'h00,
        8'hA4, 8'hA8, 8'h3F, 8'hAD, 8'h8E, 8'hB0, 8'h0B, 8'hB1,
        8'h31, 8'hB3, 8'hF0, 8'h8A, 8'h64, 8'h8B, 8'h78, 8'h8C,
        8'h64, 8'hBB, 8'h3A, 8'hBE, 8'h3E, 8'h87, 8'h06, 8'h81,
        8'h91, 8'h82, 8'h50, 8'h83, 8'h7D, 8'h15, 8'h00, 8'h5F,
        8'h75, 8'h00, 8'h3F, 8'hAF
    };

    // 5x7 hex digits listed top row first with bit 4 as the leftmost pixel
    localparam logic [0:15][0:6][4:0] GLYPH_ROM = {
        {5'h0E, 5'h11, 5'h13, 5'h15, 5'h19, 5'h11, 5'h0E},
        {5'h04, 5'h0C, 5'h04, 5'h04, 5'h04, 5'h04, 5'h0E},
        {5'h0E, 5'h11, 5'h01, 5'h02, 5'h04, 5'h08, 5'h1F},
        {5'h1F, 5'h02, 5'h04, 5'h02, 5'h01, 5'h11, 5'h0E},
        {5'h02, 5'h06, 5'h0A, 5'h12, 5'h1F, 5'h02, 5'h02},
        {5'h1F, 5'h10, 5'h1E, 5'h01, 5'h01, 5'h11, 5'h0E},
        {5'h06, 5'h08, 5'h10, 5'h1E, 5'h11, 5'h11, 5'h0E},
        {5'h1F, 5'h01, 5'h02, 5'h04, 5'h08, 5'h08, 5'h08},
        {5'h0E, 5'h11, 5'h11, 5'h0E, 5'h11, 5'h11, 5'h0E},
        {5'h0E, 5'h11, 5'h11, 5'h0F, 5'h01, 5'h02, 5'h0C},
        {5'h0E, 5'h11, 5'h11, 5'h11, 5'h1F, 5'h11, 5'h11},
        {5'h1E, 5'h11, 5'h11, 5'h1E, 5'h11, 5'h11, 5'h1E},
        {5'h0E, 5'h11, 5'h10, 5'h10, 5'h10, 5'h11, 5'h0E},
        {5'h1C, 5'h12, 5'h11, 5'h11, 5'h11, 5'h12, 5'h1C},
        {5'h1F, 5'h10, 5'h10, 5'h1E, 5'h10, 5'h10, 5'h1F},
        {5'h1F, 5'h10, 5'h10, 5'h1E, 5'h10, 5'h10, 5'h10}
    };

    localparam logic [COLOR_BITS-1:0] FG_COLOR = '1;
    localparam logic [COLOR_BITS-1:0] BG_COLOR = '0;

    typedef struct packed {
        logic [6:0] x;
        logic [5:0] y;
    } pixel_pos_t;

    typedef struct packed {
        logic [63:0] counter;
        logic [63:0] buttons;
    } status_fields_t;

    // nibble 31 is the leftmost character of text row 1
    typedef union packed {
        status_fields_t  fields;
        logic [31:0][3:0] nibbles;
    } status_word_t;

endpackage

//--- design/display_regs.sv
`timescale 1ns/1ps

module display_regs
    import hex_oled_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    input  logic [6:0]   btn,
    input  logic         frame_start,
    output status_word_t status
);

    status_fields_t next_fields;

    // value loaded at the next frame boundary
    always_comb
    begin
        next_fields = '0;
        next_fields.counter = status.fields.counter + 64'd1;
        // each button sits in the lowest bit of its own nibble
        for (int k = 0; k < 7; k++)
        begin
            next_fields.buttons[4*k] = btn[k];
        end
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            status <= '0;
        end
        else if (frame_start)
        begin
            status.fields <= next_fields;
        end
    end

    // a frame is drawn from one consistent snapshot
    a_status_frame_only: assert property (
        @(posedge clk) disable iff (!rst_n)
        !$past(frame_start) |-> $stable(status)
    )
    else $error("status changed outside a frame boundary");

    // the video side sends one strobe per frame, never a level
    a_frame_start_pulse: assert property (
        @(posedge clk) disable iff (!rst_n)
        frame_start |=> !frame_start
    )
    else $error("frame_start held for more than one cycle");

endmodule

//--- design/hex_glyph_gen.sv
`timescale 1ns/1ps

module hex_glyph_gen
    import hex_oled_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  status_word_t          status,
    input  pixel_pos_t            pos,
    output logic [COLOR_BITS-1:0] color
);

    logic [3:0] char_col;
    logic [2:0] text_row;
    logic [2:0] cell_x;
    logic [2:0] cell_y;
    logic [4:0] nib_idx;
    logic [3:0] digit;
    logic [2:0] font_row;
    logic [2:0] font_bit;
    logic [4:0] glyph_bits;
    logic       in_text;
    logic       in_glyph;
    logic       lit;

    // cell coordinates
    always_comb
    begin
        char_col = 4'(pos.x / CELL_W);
        cell_x   = 3'(pos.x % CELL_W);
        text_row = 3'(pos.y / CELL_H);
        cell_y   = 3'(pos.y % CELL_H);
    end

    // leftmost character shows the most significant nibble of its row
    always_comb
    begin
        nib_idx = 5'(int'(text_row) * CHARS_PER_ROW + CHARS_PER_ROW - 1 - int'(char_col));
        digit   = status.nibbles[nib_idx];
    end

    // last column and last row of each cell are spacing
    always_comb
    begin
        in_text  = text_row < 3'(TEXT_ROWS);
        in_glyph = (cell_x < 3'(CELL_W - 1)) && (cell_y < 3'(CELL_H - 1));
    end

    always_comb
    begin
        if (cell_y < 3'(CELL_H - 1))
        begin
            font_row = cell_y;
        end
        else
        begin
            font_row = 3'd0;
        end
        if (cell_x < 3'(CELL_W - 1))
        begin
            font_bit = 3'(CELL_W - 2 - int'(cell_x));
        end
        else
        begin
            font_bit = 3'd0;
        end
    end

    always_comb
    begin
        glyph_bits = GLYPH_ROM[digit][font_row];
        lit        = in_text && in_glyph && glyph_bits[font_bit];
    end

    // one clock from pos to color
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            color <= BG_COLOR;
        end
        else
        begin
            color <= lit ? FG_COLOR : BG_COLOR;
        end
    end

    a_pos_in_panel: assert property (
        @(posedge clk) disable iff (!rst_n)
        (int'(pos.x) < X_SIZE) && (int'(pos.y) < Y_SIZE)
    )
    else $error("pixel position outside the panel");

endmodule

//--- design/spi_byte_tx.sv
`timescale 1ns/1ps

module spi_byte_tx
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       load,
    input  logic [7:0] data,
    input  logic       dc,
    output logic       busy,
    output logic       spi_csn,
    output logic       spi_clk,
    output logic       spi_mosi,
    output logic       spi_dc
);

    logic [7:0] shift_q;
    logic [3:0] bit_cnt;
    logic       sclk_q;
    logic       dc_q;

    // sclk toggles on every clock for 16 half periods per byte
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            busy    <= 1'b0;
            bit_cnt <= 4'd0;
            sclk_q  <= 1'b0;
            shift_q <= 8'd0;
            dc_q    <= 1'b0;
        end
        else if (load)
        begin
            busy    <= 1'b1;
            bit_cnt <= 4'd0;
            sclk_q  <= 1'b0;
            shift_q <= data;
            dc_q    <= dc;
        end
        else if (busy)
        begin
            sclk_q  <= ~sclk_q;
            bit_cnt <= bit_cnt + 4'd1;
            // next bit goes out with the falling edge
            if (sclk_q)
            begin
                shift_q <= {shift_q[6:0], 1'b0};
            end
            if (bit_cnt == 4'd15)
            begin
                busy <= 1'b0;
            end
        end
    end

    assign spi_csn  = ~busy;
    assign spi_clk  = sclk_q;
    assign spi_mosi = shift_q[7];
    assign spi_dc   = dc_q;

    // the sequencer must wait for the previous byte to finish
    a_no_load_while_busy: assert property (
        @(posedge clk) disable iff (!rst_n)
        load |-> !busy
    )
    else $error("byte loaded while serialiser busy");

    // every byte keeps chip select low for exactly 16 clocks
    a_csn_width: assert property (
        @(posedge clk) disable iff (!rst_n)
        load |=> (!spi_csn)[*16] ##1 spi_csn
    )
    else $error("chip select width is not 16 clocks");

endmodule

//--- design/oled_video.sv
`timescale 1ns/1ps

module oled_video
    import hex_oled_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [COLOR_BITS-1:0] color,
    output pixel_pos_t            pos,
    output logic                  frame_start,
    output logic                  spi_csn,
    output logic                  spi_clk,
    output logic                  spi_mosi,
    output logic                  spi_dc,
    output logic                  spi_resn
);

    typedef enum logic [2:0] {
        ST_RESET,
        ST_INIT,
        ST_FRAME,
        ST_ADDR,
        ST_PIX_HI,
        ST_PIX_LO
    } state_t;

    state_t     state;
    logic [6:0] rst_cnt;
    logic [5:0] init_idx;
    logic       tx_load;
    logic [7:0] tx_data;
    logic       tx_dc;
    logic       busy;

    // a byte is requested only while the serialiser is idle
    always_comb
    begin
        tx_load = 1'b0;
        tx_data = INIT_SEQ[init_idx];
        tx_dc   = 1'b0;
        case (state)
            ST_INIT:
            begin
                tx_load = !busy;
            end
            ST_PIX_HI:
            begin
                tx_load = !busy;
                tx_data = color[COLOR_BITS-1 -: 8];
                tx_dc   = 1'b1;
            end
            ST_PIX_LO:
            begin
                tx_load = !busy;
                tx_data = color[7:0];
                tx_dc   = 1'b1;
            end
            default:
            begin
                tx_load = 1'b0;
            end
        endcase
    end

    // status updates in this cycle, before pixel (0,0) is looked up
    assign frame_start = (state == ST_FRAME);

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state    <= ST_RESET;
            rst_cnt  <= 7'd0;
            init_idx <= 6'd0;
            pos      <= '0;
            spi_resn <= 1'b0;
        end
        else
        begin
            case (state)
                ST_RESET:
                begin
                    rst_cnt <= rst_cnt + 7'd1;
                    if (rst_cnt == 7'(RESET_CYCLES - 1))
                    begin
                        spi_resn <= 1'b1;
                        state    <= ST_INIT;
                    end
                end
                ST_INIT:
                begin
                    if (tx_load)
                    begin
                        if (init_idx == 6'(INIT_LEN - 1))
                        begin
                            state <= ST_FRAME;
                        end
                        else
                        begin
                            init_idx <= init_idx + 6'd1;
                        end
                    end
                end
                ST_FRAME:
                begin
                    state <= ST_ADDR;
                end
                // color for the new pos is ready one clock later
                ST_ADDR:
                begin
                    state <= ST_PIX_HI;
                end
                ST_PIX_HI:
                begin
                    if (tx_load)
                    begin
                        state <= ST_PIX_LO;
                    end
                end
                ST_PIX_LO:
                begin
                    if (tx_load)
                    begin
                        state <= ST_ADDR;
                        if (pos.x == 7'(X_SIZE - 1))
                        begin
                            pos.x <= 7'd0;
                            if (pos.y == 6'(Y_SIZE - 1))
                            begin
                                pos.y <= 6'd0;
                                state <= ST_FRAME;
                            end
                            else
                            begin
                                pos.y <= pos.y + 6'd1;
                            end
                        end
                        else
                        begin
                            pos.x <= pos.x + 7'd1;
                        end
                    end
                end
                default:
                begin
                    state <= ST_RESET;
                end
            endcase
        end
    end

    spi_byte_tx u_spi_byte_tx
    (
        .clk      (clk),
        .rst_n    (rst_n),
        .load     (tx_load),
        .data     (tx_data),
        .dc       (tx_dc),
        .busy     (busy),
        .spi_csn  (spi_csn),
        .spi_clk  (spi_clk),
        .spi_mosi (spi_mosi),
        .spi_dc   (spi_dc)
    );

    // the panel is never addressed while held in reset
    a_resn_before_csn: assert property (
        @(posedge clk) disable iff (!rst_n)
        !spi_csn |-> spi_resn
    )
    else $error("chip select active while panel in reset");

endmodule

//--- design/hex_oled_top.sv
`timescale 1ns/1ps

module hex_oled_top
    import hex_oled_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic [6:0] btn,
    output logic       oled_csn,
    output logic       oled_clk,
    output logic       oled_mosi,
    output logic       oled_dc,
    output logic       oled_resn
);

    status_word_t          status;
    pixel_pos_t            pos;
    logic [COLOR_BITS-1:0] color;
    logic                  frame_start;

    display_regs u_display_regs
    (
        .clk         (clk),
        .rst_n       (rst_n),
        .btn         (btn),
        .frame_start (frame_start),
        .status      (status)
    );

    hex_glyph_gen u_hex_glyph_gen
    (
        .clk    (clk),
        .rst_n  (rst_n),
        .status (status),
        .pos    (pos),
        .color  (color)
    );

    oled_video u_oled_video
    (
        .clk         (clk),
        .rst_n       (rst_n),
        .color       (color),
        .pos         (pos),
        .frame_start (frame_start),
        .spi_csn     (oled_csn),
        .spi_clk     (oled_clk),
        .spi_mosi    (oled_mosi),
        .spi_dc      (oled_dc),
        .spi_resn    (oled_resn)
    );

endmodule

//--- dv/oled_spi_model.sv
`timescale 1ns/1ps

module oled_spi_model
    import hex_oled_pkg::*;
(
    input  logic csn,
    input  logic sclk,
    input  logic mosi,
    input  logic dc,
    output int   cmd_count,
    output int   frames_done,
    output int   pixel_bytes,
    output int   err_count
);

    logic [7:0]  shreg = '0;
    logic [7:0]  hi_byte = '0;
    logic        byte_dc = 1'b0;
    int          bit_cnt = 0;
    int          cmd_cnt = 0;
    int          frame_cnt = 0;
    int          pix_bytes = 0;
    int          errs = 0;
    logic [7:0]  cmd_buf [0:INIT_LEN-1];
    logic [15:0] fb [0:X_SIZE*Y_SIZE-1];

    // mosi is stable on the rising clock edge and a byte ends when csn rises
    always @(posedge sclk or posedge csn)
    begin
        if (csn)
        begin
            if (bit_cnt != 0)
            begin
                if (bit_cnt != 8)
                begin
                    $display("panel model saw a byte with %0d clock edges instead of 8", bit_cnt);
                    errs++;
                end
                if (!byte_dc)
                begin
                    if (cmd_cnt < INIT_LEN)
                    begin
                        cmd_buf[cmd_cnt] = shreg;
                    end
                    cmd_cnt++;
                end
                else
                begin
                    // high byte first, then low byte
                    if (pix_bytes % 2 == 0)
                    begin
                        hi_byte = shreg;
                    end
                    else
                    begin
                        fb[pix_bytes / 2] = {hi_byte, shreg};
                    end
                    pix_bytes++;
                    if (pix_bytes == 2 * X_SIZE * Y_SIZE)
                    begin
                        pix_bytes = 0;
                        frame_cnt++;
                    end
                end
            end
            bit_cnt = 0;
        end
        else
        begin
            shreg = {shreg[6:0], mosi};
            if (bit_cnt == 0)
            begin
                byte_dc = dc;
            end
            else if (dc != byte_dc)
            begin
                $display("panel model saw the data/command line change inside a byte");
                errs++;
            end
            bit_cnt++;
        end
    end

    assign cmd_count   = cmd_cnt;
    assign frames_done = frame_cnt;
    assign pixel_bytes = pix_bytes;
    assign err_count   = errs;

endmodule

//--- dv/tb_hex_oled.sv
`timescale 1ns/1ps

module tb_hex_oled
    import hex_oled_pkg::*;
();

    localparam int FRAMES     = 3;
    localparam int NUM_TESTS  = 6;
    localparam int WAIT_LIMIT = 300000;

    logic clk;
    logic rst_n;
    logic [6:0] btn;
    logic oled_csn;
    logic oled_clk;
    logic oled_mosi;
    logic oled_dc;
    logic oled_resn;
    int   cmd_seen;
    int   frames_seen;
    int   pixel_bytes;
    int   panel_errors;
    int   seed;
    int   rnd;
    int   tests_run = 0;
    int   tests_failed = 0;
    int   timeouts = 0;
    int   assert_errors = 0;

    hex_oled_top uut
    (
        .clk       (clk),
        .rst_n     (rst_n),
        .btn       (btn),
        .oled_csn  (oled_csn),
        .oled_clk  (oled_clk),
        .oled_mosi (oled_mosi),
        .oled_dc   (oled_dc),
        .oled_resn (oled_resn)
    );

    oled_spi_model panel
    (
        .csn         (oled_csn),
        .sclk        (oled_clk),
        .mosi        (oled_mosi),
        .dc          (oled_dc),
        .cmd_count   (cmd_seen),
        .frames_done (frames_seen),
        .pixel_bytes (pixel_bytes),
        .err_count   (panel_errors)
    );

    initial
    begin
        clk = 1'b0;
        forever
        begin
            #5 clk = ~clk;
        end
    end

    a_csn_high_in_reset: assert property (
        @(posedge clk) disable iff (!rst_n)
        !oled_resn |-> oled_csn
    )
    else
    begin
        $display("chip select went low while the panel was held in reset");
        assert_errors++;
    end

    a_sclk_idle_low: assert property (
        @(posedge clk) disable iff (!rst_n)
        oled_csn |-> !oled_clk
    )
    else
    begin
        $display("spi clock not idle low between bytes");
        assert_errors++;
    end

    a_dc_steady: assert property (
        @(posedge clk) disable iff (!rst_n)
        (!oled_csn && $past(!oled_csn)) |-> $stable(oled_dc)
    )
    else
    begin
        $display("data/command line changed inside a byte");
        assert_errors++;
    end

    a_mosi_steady: assert property (
        @(posedge clk) disable iff (!rst_n)
        (!oled_csn && $rose(oled_clk)) |-> $stable(oled_mosi)
    )
    else
    begin
        $display("mosi changed at a rising spi clock edge");
        assert_errors++;
    end

    // nothing but pixel data after the init table
    a_no_late_cmd: assert property (
        @(posedge clk) disable iff (!rst_n)
        (!oled_csn && !oled_dc) |-> (cmd_seen < INIT_LEN)
    )
    else
    begin
        $display("command byte sent after the init sequence");
        assert_errors++;
    end

    function automatic logic [15:0] expected_pixel(input int x, input int y,
                                                   input logic [6:0] b, input logic [63:0] n);
        int         k;
        int         cx;
        int         cy;
        logic [3:0] digit;
        k  = CHARS_PER_ROW - 1 - x / CELL_W;
        cx = x % CELL_W;
        cy = y % CELL_H;
        if (y / CELL_H >= TEXT_ROWS || cx == CELL_W - 1 || cy == CELL_H - 1)
        begin
            return BG_COLOR;
        end
        // row 0 shows button k in nibble k, row 1 the frame number
        if (y / CELL_H == 0)
        begin
            digit = (k < 7) ? {3'b000, b[k]} : 4'h0;
        end
        else
        begin
            digit = n[4*k +: 4];
        end
        return GLYPH_ROM[digit][cy][4 - cx] ? FG_COLOR : BG_COLOR;
    endfunction

    function automatic int check_frame(input string name, input logic [6:0] b,
                                       input logic [63:0] n);
        int          errs;
        logic [15:0] exp_px;
        logic [15:0] act_px;
        errs = 0;
        for (int y = 0; y < Y_SIZE; y++)
        begin
            for (int x = 0; x < X_SIZE; x++)
            begin
                exp_px = expected_pixel(x, y, b, n);
                act_px = panel.fb[y * X_SIZE + x];
                if (act_px !== exp_px)
                begin
                    if (errs < 8)
                    begin
                        $display("Fail %s pixel (%0d,%0d) expected %h actual %h",
                                 name, x, y, exp_px, act_px);
                    end
                    errs++;
                end
            end
        end
        return errs;
    endfunction

    task automatic report_test(input string name, input int errs);
        tests_run++;
        if (errs == 0)
        begin
            $display("test %s passed", name);
        end
        else
        begin
            $display("test %s failed with %0d errors", name, errs);
            tests_failed++;
        end
    endtask

    // waits until the panel has seen min_bytes data bytes of the given frame
    task automatic wait_frame_bytes(input int frame, input int min_bytes, output bit ok);
        int cycles;
        cycles = 0;
        ok = 1'b0;
        while (!ok && cycles < WAIT_LIMIT)
        begin
            @(negedge clk);
            cycles++;
            ok = (frames_seen > frame) || (frames_seen == frame && pixel_bytes >= min_bytes);
        end
        if (!ok)
        begin
            $display("timeout: panel frame %0d did not reach %0d data bytes", frame, min_bytes);
            timeouts++;
        end
    endtask

    task automatic run_tests();
        int         errs;
        int         cycles;
        bit         ok;
        logic [6:0] held;
        string      name;
        errs = 0;
        cycles = 0;
        while (!oled_resn && cycles < 1000)
        begin
            @(negedge clk);
            cycles++;
            if (!oled_csn)
            begin
                $display("chip select went low during the panel reset phase");
                errs++;
            end
        end
        if (cycles != RESET_CYCLES)
        begin
            $display("Fail reset expected %0d actual %0d", RESET_CYCLES, cycles);
            errs++;
        end
        report_test("reset", errs);
        for (int f = 0; f < FRAMES; f++)
        begin
            wait_frame_bytes(f, 1, ok);
            if (!ok)
            begin
                return;
            end
            held = btn;
            if (f == 0)
            begin
                errs = 0;
                for (int i = 0; i < INIT_LEN; i++)
                begin
                    if (panel.cmd_buf[i] !== INIT_SEQ[i])
                    begin
                        $display("Fail init byte %0d expected %h actual %h",
                                 i, INIT_SEQ[i], panel.cmd_buf[i]);
                        errs++;
                    end
                end
                if (cmd_seen != INIT_LEN)
                begin
                    $display("Fail init count expected %0d actual %0d", INIT_LEN, cmd_seen);
                    errs++;
                end
                report_test("init", errs);
            end
            // new buttons only in the middle of a frame
            wait_frame_bytes(f, X_SIZE * Y_SIZE, ok);
            if (!ok)
            begin
                return;
            end
            @(negedge clk);
            rnd = $random(seed);
            btn = rnd[6:0];
            wait_frame_bytes(f + 1, 0, ok);
            if (!ok)
            begin
                return;
            end
            name = $sformatf("frame%0d", f);
            report_test(name, check_frame(name, held, 64'(f + 1)));
        end
        errs = assert_errors + panel_errors;
        if (cmd_seen != INIT_LEN)
        begin
            $display("Fail protocol command count expected %0d actual %0d", INIT_LEN, cmd_seen);
            errs++;
        end
        report_test("protocol", errs);
    endtask

    initial
    begin
        seed = 32'haf9e2d1d;
        rst_n = 1'b0;
        rnd = $random(seed);
        btn = rnd[6:0];
        repeat (16) @(negedge clk);
        rst_n = 1'b1;
        run_tests();
        $display("tests run %0d, failed %0d, timeouts %0d, assertion errors %0d",
                 tests_run, tests_failed, timeouts, assert_errors);
        if (tests_run == NUM_TESTS && tests_failed == 0 && timeouts == 0 && assert_errors == 0)
        begin
            $display("Regression passed");
        end
        else
        begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

//--- compile.f
design/hex_oled_pkg.sv
design/display_regs.sv
design/hex_glyph_gen.sv
design/spi_byte_tx.sv
design/oled_video.sv
design/hex_oled_top.sv
dv/oled_spi_model.sv
dv/tb_hex_oled.sv

//--- Makefile
VERILATOR  ?= verilator
TB_TOP     ?= tb_hex_oled
RTL_TOP    ?= hex_oled_top
FILELIST   ?= compile.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
LINT_FLAGS ?= --lint-only --timing
SIM_FLAGS  ?= --binary --timing --assert -Wno-fatal
FAIL_MSG   ?= Regression failed
PASS_MSG   ?= Regression passed

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TB_TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TB_TOP)

sim: build
	./$(BUILD_DIR)/V$(TB_TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation did not complete"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
